//--- rtl/sound_pkg.sv
`default_nettype none

package sound_pkg;

  // Bus and datapath widths
  localparam int ADDR_W   = 16;
  localparam int SAMPLE_W = 8;
  localparam int MIX_W    = 12;
  localparam int SOUND_W  = 16;

  typedef logic [SAMPLE_W-1:0] sample_t;
  typedef logic [MIX_W-1:0]    mix_t;
  typedef logic [SOUND_W-1:0]  sound_t;

  // Two views of one I/O address
  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } io_addr_bytes_t;

  typedef union packed {
    logic [ADDR_W-1:0] word;
    io_addr_bytes_t    bytes;
  } io_addr_u;

  // Soundrive low-byte ports
  localparam logic [7:0] PORT_SDRV_A = 8'h0F;
  localparam logic [7:0] PORT_SDRV_B = 8'h1F;
  localparam logic [7:0] PORT_SDRV_C = 8'h4F;
  localparam logic [7:0] PORT_SDRV_D = 8'h5F;

  // Covox port, loads A and D at once
  localparam logic [7:0] PORT_COVOX  = 8'hFB;

  // Beeper bit in the #xxFE byte
  localparam int BEEPER_BIT = 4;

  // Compressor
  localparam mix_t MIX_KNEE  = 12'd1536;
  localparam int   OUT_SHIFT = 4;

  // Decode, latch, mix, compress
  localparam int SOUND_LATENCY = 4;

endpackage

`default_nettype wire

//--- rtl/io_write_decode.sv
`timescale 1ns/1ns
`default_nettype none

module io_write_decode
  import sound_pkg::*;
(
  input  logic       fclk,
  input  logic       reset,
  input  io_addr_u   addr,
  input  sample_t    data,
  input  logic       iorq_n,
  input  logic       wr_n,
  input  logic       dos,
  output logic [3:0] chan_we,
  output logic       beeper_we,
  output sample_t    wr_byte
);

  logic       io_wr;
  logic       sdrv_wr;
  logic       beep_wr;
  logic [7:0] port_lo;
  logic [3:0] chan_hit;

  // One write per clock with both strobes low
  assign io_wr = ~iorq_n & ~wr_n;

  // Soundrive only outside the DOS window
  assign sdrv_wr = io_wr & ~dos;

  // Any even port reaches #xxFE
  assign beep_wr = io_wr & ~addr.word[0];

  assign port_lo = addr.bytes.lo;

  always_comb begin
    chan_hit[0] = (port_lo == PORT_SDRV_A) || (port_lo == PORT_COVOX);
    chan_hit[1] = (port_lo == PORT_SDRV_B);
    chan_hit[2] = (port_lo == PORT_SDRV_C);
    chan_hit[3] = (port_lo == PORT_SDRV_D) || (port_lo == PORT_COVOX);
  end

  always_ff @(posedge fclk) begin
    if (reset) begin
      chan_we   <= 4'b0000;
      beeper_we <= 1'b0;
    end else begin
      chan_we   <= sdrv_wr ? chan_hit : 4'b0000;
      beeper_we <= beep_wr;
    end
  end

  // Data rides beside the strobes
  always_ff @(posedge fclk) begin
    if (io_wr) begin
      wr_byte <= data;
    end
  end

endmodule

`default_nettype wire

//--- rtl/dac_latches.sv
`timescale 1ns/1ns
`default_nettype none

module dac_latches
  import sound_pkg::*;
(
  input  logic       fclk,
  input  logic       reset,
  input  logic [3:0] chan_we,
  input  logic       beeper_we,
  input  sample_t    wr_byte,
  output sample_t    chan_a,
  output sample_t    chan_b,
  output sample_t    chan_c,
  output sample_t    chan_d,
  output logic       beeper
);

  // Channels A to D by strobe index
  sample_t chan_q [4];
  logic    beeper_q;

  always_ff @(posedge fclk) begin
    if (reset) begin
      for (int i = 0; i < 4; i++) begin
        chan_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (chan_we[i]) begin
          chan_q[i] <= wr_byte;
        end
      end
    end
  end

  // Port #xxFE keeps only the beeper bit
  always_ff @(posedge fclk) begin
    if (reset) begin
      beeper_q <= 1'b0;
    end else if (beeper_we) begin
      beeper_q <= wr_byte[BEEPER_BIT];
    end
  end

  assign chan_a = chan_q[0];
  assign chan_b = chan_q[1];
  assign chan_c = chan_q[2];
  assign chan_d = chan_q[3];
  assign beeper = beeper_q;

endmodule

`default_nettype wire

//--- rtl/audio_mixer.sv
`timescale 1ns/1ns
`default_nettype none

module audio_mixer
  import sound_pkg::*;
(
  input  logic    fclk,
  input  logic    reset,
  input  sample_t chan_a,
  input  sample_t chan_b,
  input  sample_t chan_c,
  input  sample_t chan_d,
  input  logic    beeper,
  output mix_t    mix_l,
  output mix_t    mix_r
);

  mix_t sum_l;
  mix_t sum_r;

  // Two channels at x4 plus the beeper at 256, peak 2296
  function automatic mix_t mix_side(input sample_t x, input sample_t y, input logic beep);
    mix_t x_term;
    mix_t y_term;
    mix_t b_term;
    x_term = {2'b00, x, 2'b00};
    y_term = {2'b00, y, 2'b00};
    b_term = {3'b000, beep, 8'h00};
    return x_term + y_term + b_term;
  endfunction

  // Left gets A and B, right gets C and D
  assign sum_l = mix_side(chan_a, chan_b, beeper);
  assign sum_r = mix_side(chan_c, chan_d, beeper);

  always_ff @(posedge fclk) begin
    if (reset) begin
      mix_l <= '0;
      mix_r <= '0;
    end else begin
      mix_l <= sum_l;
      mix_r <= sum_r;
    end
  end

endmodule

`default_nettype wire

//--- rtl/sound_compressor.sv
`timescale 1ns/1ns
`default_nettype none

module sound_compressor
  import sound_pkg::*;
(
  input  logic   fclk,
  input  logic   reset,
  input  mix_t   mix_l,
  input  mix_t   mix_r,
  output sound_t sound_l,
  output sound_t sound_r
);

  sound_t comp_l;
  sound_t comp_r;

  // Unity gain to the knee, half slope above it
  function automatic sound_t compress(input mix_t mix);
    mix_t excess;
    mix_t knee_out;
    sound_t wide;
    excess = mix - MIX_KNEE;
    if (mix > MIX_KNEE) begin
      knee_out = MIX_KNEE + (excess >> 1);
    end else begin
      knee_out = mix;
    end
    wide = sound_t'(knee_out);
    return wide << OUT_SHIFT;
  endfunction

  assign comp_l = compress(mix_l);
  assign comp_r = compress(mix_r);

  always_ff @(posedge fclk) begin
    if (reset) begin
      sound_l <= '0;
      sound_r <= '0;
    end else begin
      sound_l <= comp_l;
      sound_r <= comp_r;
    end
  end

endmodule

`default_nettype wire

//--- rtl/sound_top.sv
`timescale 1ns/1ns
`default_nettype none

module sound_top
  import sound_pkg::*;
(
  input  logic     fclk,
  input  logic     reset,
  input  io_addr_u addr,
  input  sample_t  data,
  input  logic     iorq_n,
  input  logic     wr_n,
  input  logic     dos,
  output sound_t   sound_l,
  output sound_t   sound_r
);

  // Decode to latches
  logic [3:0] chan_we;
  logic       beeper_we;
  sample_t    wr_byte;

  // Latches to mixer
  sample_t    chan_a;
  sample_t    chan_b;
  sample_t    chan_c;
  sample_t    chan_d;
  logic       beeper;

  // Mixer to compressor
  mix_t       mix_l;
  mix_t       mix_r;

  io_write_decode i_decode (
    .fclk      (fclk),
    .reset     (reset),
    .addr      (addr),
    .data      (data),
    .iorq_n    (iorq_n),
    .wr_n      (wr_n),
    .dos       (dos),
    .chan_we   (chan_we),
    .beeper_we (beeper_we),
    .wr_byte   (wr_byte)
  );

  dac_latches i_latches (
    .fclk      (fclk),
    .reset     (reset),
    .chan_we   (chan_we),
    .beeper_we (beeper_we),
    .wr_byte   (wr_byte),
    .chan_a    (chan_a),
    .chan_b    (chan_b),
    .chan_c    (chan_c),
    .chan_d    (chan_d),
    .beeper    (beeper)
  );

  audio_mixer i_mixer (
    .fclk   (fclk),
    .reset  (reset),
    .chan_a (chan_a),
    .chan_b (chan_b),
    .chan_c (chan_c),
    .chan_d (chan_d),
    .beeper (beeper),
    .mix_l  (mix_l),
    .mix_r  (mix_r)
  );

  sound_compressor i_compressor (
    .fclk    (fclk),
    .reset   (reset),
    .mix_l   (mix_l),
    .mix_r   (mix_r),
    .sound_l (sound_l),
    .sound_r (sound_r)
  );

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic fclk
);

  // 8 ns period
  initial begin
    fclk = 1'b0;
    forever begin
      #4 fclk = ~fclk;
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_sound.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sound
  import sound_pkg::*;
();

  // About 25 writes of 5 cycles each plus reset, with a wide margin
  localparam int CYCLE_LIMIT = 2000;

  logic     fclk;
  logic     reset;
  io_addr_u addr;
  sample_t  data;
  logic     iorq_n;
  logic     wr_n;
  logic     dos;
  sound_t   sound_l;
  sound_t   sound_r;

  integer   seed;
  int       cycles = 0;
  int       errors = 0;
  int       passed = 0;
  int       failed = 0;
  // Reference copy of channels A to D and the beeper
  sample_t  m_chan [4];
  logic     m_beep;

  tb_clock i_clock (.fclk(fclk));

  sound_top i_dut (
    .fclk    (fclk),
    .reset   (reset),
    .addr    (addr),
    .data    (data),
    .iorq_n  (iorq_n),
    .wr_n    (wr_n),
    .dos     (dos),
    .sound_l (sound_l),
    .sound_r (sound_r)
  );

  always @(posedge fclk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, a test never finished", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  // x4 per channel, 256 for the beeper, half slope above the knee
  function automatic sound_t expect_side(input sample_t x, input sample_t y, input logic beep);
    int mix;
    int level;
    mix = 4 * int'(x) + 4 * int'(y) + (beep ? 256 : 0);
    level = (mix > int'(MIX_KNEE)) ? int'(MIX_KNEE) + (mix - int'(MIX_KNEE)) / 2 : mix;
    return sound_t'(level * (2 ** OUT_SHIFT));
  endfunction

  task automatic model_write(input logic [15:0] a, input sample_t d, input logic dos_level);
    if (!a[0]) begin
      m_beep = d[BEEPER_BIT];
    end
    if (!dos_level) begin
      case (a[7:0])
        PORT_SDRV_A: m_chan[0] = d;
        PORT_SDRV_B: m_chan[1] = d;
        PORT_SDRV_C: m_chan[2] = d;
        PORT_SDRV_D: m_chan[3] = d;
        PORT_COVOX: begin
          m_chan[0] = d;
          m_chan[3] = d;
        end
        default: ;
      endcase
    end
  endtask

  task automatic drive_write(input logic [15:0] a, input sample_t d, input logic dos_level);
    addr.word <= a;
    data      <= d;
    dos       <= dos_level;
    iorq_n    <= 1'b0;
    wr_n      <= 1'b0;
    model_write(a, d, dos_level);
  endtask

  task automatic drive_idle();
    iorq_n <= 1'b1;
    wr_n   <= 1'b1;
    dos    <= 1'b0;
  endtask

  task automatic check_sound(input string what, input sound_t got, input sound_t want);
    if (got !== want) begin
      errors++;
      $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, want);
    end
  endtask

  task automatic check_outputs(input string what);
    check_sound({"left ", what}, sound_l, expect_side(m_chan[0], m_chan[1], m_beep));
    check_sound({"right ", what}, sound_r, expect_side(m_chan[2], m_chan[3], m_beep));
  endtask

  task automatic write_and_check(input logic [15:0] a, input sample_t d, input logic dos_level);
    sound_t old_l;
    sound_t old_r;
    old_l = expect_side(m_chan[0], m_chan[1], m_beep);
    old_r = expect_side(m_chan[2], m_chan[3], m_beep);
    @(posedge fclk);
    drive_write(a, d, dos_level);
    @(posedge fclk);
    drive_idle();
    // One cycle short of the latency the old value must remain
    repeat (SOUND_LATENCY - 2) @(posedge fclk);
    @(negedge fclk);
    check_sound($sformatf("left before write to %h", a), sound_l, old_l);
    check_sound($sformatf("right before write to %h", a), sound_r, old_r);
    @(posedge fclk);
    @(negedge fclk);
    check_outputs($sformatf("after write to %h", a));
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      passed++;
      $display("Test %s: ok", name);
    end else begin
      failed++;
      $display("Test %s: %0d mismatches", name, errors - errs_before);
    end
  endtask

  task automatic check_reset_state();
    @(negedge fclk);
    check_sound("left after reset", sound_l, 16'd0);
    check_sound("right after reset", sound_r, 16'd0);
  endtask

  task automatic sweep_soundrive_ports();
    logic [7:0] ports [4];
    ports = '{PORT_SDRV_A, PORT_SDRV_B, PORT_SDRV_C, PORT_SDRV_D};
    for (int i = 0; i < 4; i++) begin
      write_and_check({sample_t'($random(seed)), ports[i]}, sample_t'($random(seed)), 1'b0);
    end
  endtask

  task automatic covox_and_dos();
    write_and_check(16'h00FB, sample_t'($random(seed)), 1'b0);
    write_and_check(16'h00FB, sample_t'($random(seed)), 1'b1);
    write_and_check(16'h3C0F, sample_t'($random(seed)), 1'b1);
    write_and_check(16'h005F, sample_t'($random(seed)), 1'b1);
  endtask

  task automatic beeper_ports();
    write_and_check(16'h00FE, 8'h10, 1'b1);
    write_and_check(16'h7FFE, 8'hEF, 1'b0);
    write_and_check(16'h0010, 8'h10, 1'b0);
    // Odd port, bit 4 low, beeper stays on
    write_and_check(16'h00FF, 8'h00, 1'b0);
  endtask

  task automatic knee_limits();
    write_and_check(16'h000F, 8'hFF, 1'b0);
    write_and_check(16'h001F, 8'hFF, 1'b0);
    write_and_check(16'h004F, 8'hFF, 1'b0);
    write_and_check(16'h005F, 8'hFF, 1'b0);
    write_and_check(16'h00FE, 8'h10, 1'b0);
    // Mix 2296, knee 1536 plus 380
    check_sound("left at full scale", sound_l, 16'd30656);
    write_and_check(16'h00FE, 8'h00, 1'b0);
    write_and_check(16'h000F, 8'd192, 1'b0);
    write_and_check(16'h001F, 8'd192, 1'b0);
    check_sound("left exactly at knee", sound_l, 16'd24576);
    write_and_check(16'h004F, 8'd200, 1'b0);
    write_and_check(16'h005F, 8'd184, 1'b0);
    check_sound("right exactly at knee", sound_r, 16'd24576);
    write_and_check(16'h000F, 8'd193, 1'b0);
  endtask

  task automatic back_to_back_writes();
    logic [7:0] ports [4];
    sound_t     want_l [4];
    sound_t     want_r [4];
    ports = '{PORT_SDRV_A, PORT_SDRV_C, PORT_SDRV_B, PORT_SDRV_D};
    @(posedge fclk);
    for (int i = 0; i < 4; i++) begin
      drive_write({8'h00, ports[i]}, sample_t'($random(seed)), 1'b0);
      want_l[i] = expect_side(m_chan[0], m_chan[1], m_beep);
      want_r[i] = expect_side(m_chan[2], m_chan[3], m_beep);
      @(posedge fclk);
    end
    drive_idle();
    // First write lands on the edge just passed, the rest follow one per cycle
    for (int i = 0; i < 4; i++) begin
      @(negedge fclk);
      check_sound($sformatf("left in flight %0d", i), sound_l, want_l[i]);
      check_sound($sformatf("right in flight %0d", i), sound_r, want_r[i]);
      @(posedge fclk);
    end
  endtask

  initial begin
    int errs;
    seed      = 32'h8f12196e;
    m_chan    = '{default: '0};
    m_beep    = 1'b0;
    reset     <= 1'b1;
    addr.word <= 16'hFFFF;
    data      <= 8'h00;
    iorq_n    <= 1'b1;
    wr_n      <= 1'b1;
    dos       <= 1'b0;
    repeat (10) @(posedge fclk);
    reset <= 1'b0;

    errs = errors;
    check_reset_state();
    finish_test("reset state", errs);
    errs = errors;
    sweep_soundrive_ports();
    finish_test("soundrive ports", errs);
    errs = errors;
    covox_and_dos();
    finish_test("covox and dos", errs);
    errs = errors;
    beeper_ports();
    finish_test("beeper", errs);
    errs = errors;
    knee_limits();
    finish_test("compressor knee", errs);
    errs = errors;
    back_to_back_writes();
    finish_test("back to back writes", errs);

    $display("Summary: %0d tests passed, %0d tests failed", passed, failed);
    if (failed == 0 && errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
rtl/sound_pkg.sv
rtl/io_write_decode.sv
rtl/dac_latches.sv
rtl/audio_mixer.sv
rtl/sound_compressor.sv
rtl/sound_top.sv
verif/tb_clock.sv
verif/tb_sound.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ns --top-module tb_sound \
  -f files.f -o tb_sound_sim > sim.log 2>&1 &&
  ./obj_dir/tb_sound_sim >> sim.log 2>&1 ||
  { cat sim.log; echo "Build or simulation run did not complete"; exit 1; }
cat sim.log
grep -q 'Test failures found' sim.log && exit 1
grep -q 'All tests passed!' sim.log || { echo "No pass line in sim.log"; exit 1; }
exit 0
